/* hdl/controller_defs.svh */
// Controller constants
// Opcodes, funct3 codes, ALU codes, datapath selector codes and bus command kinds
`ifndef CONTROLLER_DEFS_SVH
`define CONTROLLER_DEFS_SVH

// Supported opcodes
`define OP_LOAD       7'b0000011 // lw
`define OP_STORE      7'b0100011 // sw
`define OP_RTYPE      7'b0110011
`define OP_ITYPE      7'b0010011 // I-type ALU
`define OP_JAL        7'b1101111
`define OP_BRANCH     7'b1100011 // beq

// Supported funct3 codes for R and I
`define F3_ADDSUB     3'b000
`define F3_XOR        3'b100
`define F3_OR         3'b110
`define F3_AND        3'b111
`define F3_SLT        3'b010

// ALU control
`define ALU_ADD       3'b000
`define ALU_SUB       3'b001
`define ALU_AND       3'b010
`define ALU_OR        3'b011
`define ALU_XOR       3'b100
`define ALU_SLT       3'b101

// ALU A input mux
`define SRCA_PC       2'b00
`define SRCA_OLDPC    2'b01
`define SRCA_REG      2'b10

// ALU B input mux
`define SRCB_REG      2'b00
`define SRCB_IMM      2'b01
`define SRCB_FOUR     2'b10

// Result bus mux
`define RES_ALUOUT    2'b00
`define RES_DATA      2'b01
`define RES_ALURESULT 2'b10

// Immediate extender formats
`define IMM_I         2'b00
`define IMM_S         2'b01
`define IMM_B         2'b10
`define IMM_J         2'b11

// Bus command word
`define CMD_SET_ADDR  2'b10 // Load base address
`define CMD_READ      2'b00 // Read at base address
`define CMD_WIDTH     34
`define ADDR_BITS     30    // Word address, pc[31:2]

`endif

/* hdl/ctrlPkg.sv */
// Controller types
// FSM states, instruction classes, control word and the bus command word
package ctrlPkg;

`include "controller_defs.svh"

    // Main FSM states, code 14 unused
    typedef enum logic [3:0] {
        idle      = 4'd0,
        fetchAddr = 4'd1,  // Send address command
        pcIncr    = 4'd2,  // PC <- PC + 4
        fetchRead = 4'd3,  // Send read, wait for response
        decode    = 4'd4,
        memAddr   = 4'd5,
        memRead   = 4'd6,
        memWb     = 4'd7,
        memWrite  = 4'd8,
        executeR  = 4'd9,
        executeI  = 4'd10,
        jal       = 4'd11,
        beq       = 4'd12,
        aluWb     = 4'd13,
        error     = 4'd15  // Sticky until reset
    } ctrlState_t;

    typedef enum logic [2:0] {
        clsLoad,
        clsStore,
        clsRType,
        clsIType,
        clsJal,
        clsBranch,
        clsIllegal
    } instrClass_t;

    // Decoder result, 8 bits
    typedef struct packed {
        instrClass_t instrClass;
        logic [2:0]  aluOp;
        logic [1:0]  immFormat;
    } decodedInstr_t;

    // Datapath control word, 16 bits
    typedef struct packed {
        logic       pcWrite;
        logic       adrSrc;     // 1 = ALUOut/Result as memory address
        logic       memWrite;
        logic       irWrite;
        logic       regWrite;
        logic [1:0] resultSrc;
        logic [1:0] aluSrcA;
        logic [1:0] aluSrcB;
        logic [1:0] immSrc;
        logic [2:0] aluControl;
    } ctrlSignals_t;

    // Command word seen as address command or as data command
    typedef union packed {
        struct packed {
            logic [1:0]            kind;
            logic                  readWrite;  // 0 = read
            logic                  increment;  // Auto increment per access
            logic [`ADDR_BITS-1:0] address;
        } addrForm;
        struct packed {
            logic [1:0]  kind;
            logic [31:0] payload;
        } dataForm;
    } busCmd_u;

    typedef enum logic [1:0] {
        phaseNone,
        phaseAddr,
        phaseRead
    } fetchPhase_t;

endpackage

/* hdl/instrDecoder.sv */
// Instruction decoder
// Classifies opcode and funct fields, picks ALU operation and immediate format
`timescale 1ns/1ns

`include "controller_defs.svh"

module instrDecoder (
    input  logic [6:0]             op,
    input  logic [2:0]             funct3,
    input  logic                   funct7b5,
    output ctrlPkg::decodedInstr_t decoded
);
    import ctrlPkg::*;

    logic       isRType;
    logic [2:0] f3AluOp;   // ALU op implied by funct3
    logic       f3Ok;      // funct3 is one we support

    assign isRType = (op == `OP_RTYPE);

    // funct3 to ALU code, sub only for R-type with funct7b5
    always_comb
    begin
        f3Ok = 1'b1;
        case (funct3)
            `F3_ADDSUB: f3AluOp = (isRType && funct7b5) ? `ALU_SUB : `ALU_ADD;
            `F3_XOR:    f3AluOp = `ALU_XOR;
            `F3_OR:     f3AluOp = `ALU_OR;
            `F3_AND:    f3AluOp = `ALU_AND;
            `F3_SLT:    f3AluOp = `ALU_SLT;
            default:
            begin
                f3AluOp = `ALU_ADD;
                f3Ok    = 1'b0;    // sll, srl and friends
            end
        endcase
    end

    // Opcode to class and immediate format
    always_comb
    begin
        decoded.instrClass = clsIllegal;
        decoded.aluOp      = `ALU_ADD;   // Address and link arithmetic
        decoded.immFormat  = `IMM_I;
        case (op)
            `OP_LOAD:   decoded.instrClass = clsLoad;
            `OP_STORE:
            begin
                decoded.instrClass = clsStore;
                decoded.immFormat  = `IMM_S;
            end
            `OP_RTYPE:
            begin
                decoded.instrClass = f3Ok ? clsRType : clsIllegal;
                decoded.aluOp      = f3AluOp;
            end
            `OP_ITYPE:
            begin
                decoded.instrClass = f3Ok ? clsIType : clsIllegal;
                decoded.aluOp      = f3AluOp;
            end
            `OP_JAL:
            begin
                decoded.instrClass = clsJal;
                decoded.immFormat  = `IMM_J;
            end
            `OP_BRANCH:
            begin
                decoded.instrClass = clsBranch;
                decoded.aluOp      = `ALU_SUB;  // rs1 - rs2 for Zero
                decoded.immFormat  = `IMM_B;
            end
            default:    decoded.instrClass = clsIllegal;
        endcase
    end

endmodule

/* hdl/mainFsm.sv */
// Main controller FSM
// Steps fetch, decode, execute and write-back per instruction class
// Drives the fetch phase for the bus unit and flags the sticky error state
`timescale 1ns/1ns

module mainFsm (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrlPkg::instrClass_t instrClass,
    input  logic                 phaseDone,   // Current fetch phase completed
    output ctrlPkg::ctrlState_t  state,
    output ctrlPkg::fetchPhase_t fetchPhase,
    output logic                 halted
);
    import ctrlPkg::*;

    ctrlState_t nextState;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= idle;
        else
            state <= nextState;
    end

    // Next state
    always_comb
    begin
        nextState = state;   // Hold by default
        case (state)
            idle:      nextState = fetchAddr;
            fetchAddr: if (phaseDone) nextState = pcIncr;    // Address command sent
            pcIncr:    nextState = fetchRead;
            fetchRead: if (phaseDone) nextState = decode;    // Response arrived
            decode:
            begin
                case (instrClass)
                    clsLoad,
                    clsStore:  nextState = memAddr;
                    clsRType:  nextState = executeR;
                    clsIType:  nextState = executeI;
                    clsJal:    nextState = jal;
                    clsBranch: nextState = beq;
                    default:   nextState = error;
                endcase
            end
            memAddr:   nextState = (instrClass == clsStore) ? memWrite : memRead;
            memRead:   nextState = memWb;
            memWb:     nextState = fetchAddr;
            memWrite:  nextState = fetchAddr;
            executeR:  nextState = aluWb;
            executeI:  nextState = aluWb;
            jal:       nextState = aluWb;     // Link rd <- oldPC + 4
            beq:       nextState = fetchAddr;
            aluWb:     nextState = fetchAddr;
            error:     nextState = error;     // Only reset leaves
            default:   nextState = error;
        endcase
    end

    // Bus phase follows the fetch states
    always_comb
    begin
        case (state)
            fetchAddr: fetchPhase = phaseAddr;
            fetchRead: fetchPhase = phaseRead;
            default:   fetchPhase = phaseNone;
        endcase
    end

    assign halted = (state == error);

    // Only defined encodings, never X
    aStateLegal: assert property (@(posedge clk) disable iff (reset)
        state inside {idle, fetchAddr, pcIncr, fetchRead, decode, memAddr, memRead,
                      memWb, memWrite, executeR, executeI, jal, beq, aluWb, error});

    aErrorSticky: assert property (@(posedge clk) disable iff (reset)
        state == error |=> state == error);

    // Read phase ends only on the bus unit's done
    aReadWaits: assert property (@(posedge clk) disable iff (reset)
        (state == fetchRead && !phaseDone) |=> state == fetchRead);

endmodule

/* hdl/fetchUnit.sv */
// Fetch bus unit
// Sends the address and read commands on the command bus and tracks the response
`timescale 1ns/1ns

`include "controller_defs.svh"

module fetchUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrlPkg::fetchPhase_t fetchPhase,
    input  logic [31:0]          pc,
    input  logic                 cmdBusy,
    input  logic                 rspStb,
    output logic                 cmdStb,
    output ctrlPkg::busCmd_u     cmdWord,
    output logic                 phaseDone
);
    import ctrlPkg::*;

    logic readSent;   // Read command already out this phase

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            readSent <= 1'b0;
        else if (fetchPhase != phaseRead)
            readSent <= 1'b0;
        else if (cmdStb)
            readSent <= 1'b1;
    end

    // Strobe only into an idle bus
    assign cmdStb = !cmdBusy &&
                    ((fetchPhase == phaseAddr) || (fetchPhase == phaseRead && !readSent));

    // Command word, zero outside the strobe cycle
    always_comb
    begin
        cmdWord = '0;
        if (cmdStb && fetchPhase == phaseAddr)
        begin
            cmdWord.addrForm.kind      = `CMD_SET_ADDR;
            cmdWord.addrForm.readWrite = 1'b0;
            cmdWord.addrForm.increment = 1'b0;
            cmdWord.addrForm.address   = pc[31:2];   // Word address
        end
        else if (cmdStb)
        begin
            cmdWord.dataForm.kind    = `CMD_READ;
            cmdWord.dataForm.payload = '0;           // Ignored by the bus on reads
        end
    end

    // Address phase done with its strobe, read phase on the response
    assign phaseDone = ((fetchPhase == phaseAddr) && !cmdBusy) ||
                       ((fetchPhase == phaseRead) && readSent && rspStb);

    aStbIdle: assert property (@(posedge clk) disable iff (reset) cmdStb |-> !cmdBusy);

    aOneRead: assert property (@(posedge clk) disable iff (reset)
        (cmdStb && fetchPhase == phaseRead) |=> !cmdStb until (fetchPhase != phaseRead));

endmodule

/* hdl/ctrlEncoder.sv */
// Control word encoder
// Moore decode of the FSM state into the datapath control word
`timescale 1ns/1ns

`include "controller_defs.svh"

module ctrlEncoder (
    input  ctrlPkg::ctrlState_t    state,
    input  ctrlPkg::decodedInstr_t decoded,
    input  logic                   zero,      // ALU result zero
    output ctrlPkg::ctrlSignals_t  ctrl
);
    import ctrlPkg::*;

    always_comb
    begin
        ctrl = '0;   // Unnamed fields inactive
        case (state)
            pcIncr:
            begin
                // PC <- PC + 4
                ctrl.aluSrcA    = `SRCA_PC;
                ctrl.aluSrcB    = `SRCB_FOUR;
                ctrl.aluControl = `ALU_ADD;
                ctrl.resultSrc  = `RES_ALURESULT;
                ctrl.pcWrite    = 1'b1;
            end
            fetchRead: ctrl.irWrite = 1'b1;   // IR <- Mem[PC], adrSrc 0
            decode:
            begin
                // ALUOut <- oldPC + imm, branch/jump target
                ctrl.aluSrcA    = `SRCA_OLDPC;
                ctrl.aluSrcB    = `SRCB_IMM;
                ctrl.aluControl = `ALU_ADD;
                ctrl.immSrc     = decoded.immFormat;
            end
            memAddr:
            begin
                ctrl.aluSrcA    = `SRCA_REG;   // rs1 + imm
                ctrl.aluSrcB    = `SRCB_IMM;
                ctrl.aluControl = `ALU_ADD;
            end
            memRead:
            begin
                ctrl.adrSrc    = 1'b1;
                ctrl.resultSrc = `RES_ALUOUT;
            end
            memWb:
            begin
                ctrl.resultSrc = `RES_DATA;    // rd <- Data
                ctrl.regWrite  = 1'b1;
            end
            memWrite:
            begin
                ctrl.adrSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            executeR:
            begin
                ctrl.aluSrcA    = `SRCA_REG;
                ctrl.aluSrcB    = `SRCB_REG;
                ctrl.aluControl = decoded.aluOp;
            end
            executeI:
            begin
                ctrl.aluSrcA    = `SRCA_REG;
                ctrl.aluSrcB    = `SRCB_IMM;
                ctrl.aluControl = decoded.aluOp;
                ctrl.immSrc     = decoded.immFormat;
            end
            jal:
            begin
                // PC <- ALUOut, ALUOut <- oldPC + 4 for the link
                ctrl.aluSrcA    = `SRCA_OLDPC;
                ctrl.aluSrcB    = `SRCB_FOUR;
                ctrl.aluControl = `ALU_ADD;
                ctrl.pcWrite    = 1'b1;
            end
            beq:
            begin
                ctrl.aluSrcA    = `SRCA_REG;
                ctrl.aluSrcB    = `SRCB_REG;
                ctrl.aluControl = `ALU_SUB;
                ctrl.pcWrite    = zero;        // Taken only on equal
            end
            aluWb:
            begin
                ctrl.resultSrc = `RES_ALUOUT;  // rd <- ALUOut
                ctrl.regWrite  = 1'b1;
            end
            default: ctrl = '0;                // idle, fetchAddr, error
        endcase
    end

endmodule

/* hdl/multicycleController.sv */
// Multicycle controller top level
// Decoder, main FSM, fetch bus unit and control encoder
`timescale 1ns/1ns

module multicycleController (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [6:0]            op,
    input  logic [2:0]            funct3,
    input  logic                  funct7b5,
    input  logic                  zero,
    input  logic [31:0]           pc,
    input  logic                  cmdBusy,
    input  logic                  rspStb,
    output ctrlPkg::ctrlSignals_t ctrl,
    output logic                  cmdStb,
    output ctrlPkg::busCmd_u      cmdWord,
    output logic                  halted
);
    import ctrlPkg::*;

    decodedInstr_t decoded;
    ctrlState_t    state;
    fetchPhase_t   fetchPhase;
    logic          phaseDone;   // Fetch phase handshake back to FSM

    instrDecoder uDecoder (
        .op       (op),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .decoded  (decoded)
    );

    mainFsm uFsm (
        .clk        (clk),
        .reset      (reset),
        .instrClass (decoded.instrClass),
        .phaseDone  (phaseDone),
        .state      (state),
        .fetchPhase (fetchPhase),
        .halted     (halted)
    );

    fetchUnit uFetch (
        .clk        (clk),
        .reset      (reset),
        .fetchPhase (fetchPhase),
        .pc         (pc),
        .cmdBusy    (cmdBusy),
        .rspStb     (rspStb),
        .cmdStb     (cmdStb),
        .cmdWord    (cmdWord),
        .phaseDone  (phaseDone)
    );

    ctrlEncoder uEncoder (
        .state   (state),
        .decoded (decoded),
        .zero    (zero),
        .ctrl    (ctrl)
    );

endmodule

/* verif/tbClock.sv */
// Testbench clock and power-on reset
// 4 ns clock, reset held high for the first 8 cycles
`timescale 1ns/1ns

module tbClock (
    output logic clk,
    output logic reset
);
    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;   // Released on an edge like the other inputs
    end

    always #2 clk = ~clk;   // 4 ns period

endmodule

/* verif/tbChecker.sv */
// Controller checker
// Reference model of the FSM, fetch bus and control table, compared every cycle
`timescale 1ns/1ns

`include "controller_defs.svh"

module tbChecker (
    input logic                  clk,
    input logic                  reset,
    input logic [6:0]            op,
    input logic [2:0]            funct3,
    input logic                  funct7b5,
    input logic                  zero,
    input logic [31:0]           pc,
    input logic                  cmdBusy,
    input logic                  rspStb,
    input ctrlPkg::ctrlSignals_t ctrl,
    input logic                  cmdStb,
    input ctrlPkg::busCmd_u      cmdWord,
    input logic                  halted
);
    import ctrlPkg::*;

    int          checks = 0;
    int          errors = 0;
    ctrlState_t  mState = idle;   // Model state
    ctrlState_t  nState;
    logic        mSent  = 1'b0;   // Read command given this fetch
    logic        expStb;
    logic [33:0] expWord;
    instrClass_t cls;

    function automatic instrClass_t classOf(input logic [6:0] o, input logic [2:0] f3);
        logic f3Ok;
        f3Ok = f3 inside {`F3_ADDSUB, `F3_XOR, `F3_OR, `F3_AND, `F3_SLT};
        case (o)
            `OP_LOAD:   return clsLoad;
            `OP_STORE:  return clsStore;
            `OP_RTYPE:  return f3Ok ? clsRType : clsIllegal;
            `OP_ITYPE:  return f3Ok ? clsIType : clsIllegal;
            `OP_JAL:    return clsJal;
            `OP_BRANCH: return clsBranch;
            default:    return clsIllegal;
        endcase
    endfunction

    function automatic logic [2:0] aluOf(input logic [2:0] f3, input logic sub);
        case (f3)
            `F3_XOR: return `ALU_XOR;
            `F3_OR:  return `ALU_OR;
            `F3_AND: return `ALU_AND;
            `F3_SLT: return `ALU_SLT;
            default: return sub ? `ALU_SUB : `ALU_ADD;
        endcase
    endfunction

    function automatic logic [1:0] immOf(input instrClass_t c);
        case (c)
            clsStore:  return `IMM_S;
            clsJal:    return `IMM_J;
            clsBranch: return `IMM_B;
            default:   return `IMM_I;
        endcase
    endfunction

    // Flags: pcWrite adrSrc memWrite irWrite regWrite, then resultSrc srcA srcB imm alu
    function automatic logic [15:0] ctrlOf(input ctrlState_t st, input instrClass_t c);
        case (st)
            pcIncr:    return {5'b10000, `RES_ALURESULT, `SRCA_PC, `SRCB_FOUR, 2'b00, `ALU_ADD};
            fetchRead: return {5'b00010, 2'b00, 2'b00, 2'b00, 2'b00, 3'b000};
            decode:    return {5'b00000, 2'b00, `SRCA_OLDPC, `SRCB_IMM, immOf(c), `ALU_ADD};
            memAddr:   return {5'b00000, 2'b00, `SRCA_REG, `SRCB_IMM, 2'b00, `ALU_ADD};
            memRead:   return {5'b01000, `RES_ALUOUT, 2'b00, 2'b00, 2'b00, 3'b000};
            memWb:     return {5'b00001, `RES_DATA, 2'b00, 2'b00, 2'b00, 3'b000};
            memWrite:  return {5'b01100, 2'b00, 2'b00, 2'b00, 2'b00, 3'b000};
            executeR:  return {5'b00000, 2'b00, `SRCA_REG, `SRCB_REG, 2'b00,
                               aluOf(funct3, funct7b5)};
            executeI:  return {5'b00000, 2'b00, `SRCA_REG, `SRCB_IMM, `IMM_I,
                               aluOf(funct3, 1'b0)};
            jal:       return {5'b10000, 2'b00, `SRCA_OLDPC, `SRCB_FOUR, 2'b00, `ALU_ADD};
            beq:       return {zero, 4'b0000, 2'b00, `SRCA_REG, `SRCB_REG, 2'b00, `ALU_SUB};
            aluWb:     return {5'b00001, `RES_ALUOUT, 2'b00, 2'b00, 2'b00, 3'b000};
            default:   return 16'h0000;   // idle, fetchAddr, error
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [33:0] exp,
                                input logic [33:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %s expected 0x%h actual 0x%h in %s at %0t ns",
                     name, exp, act, mState.name(), $time);
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk)
    begin
        if (reset)
        begin
            mState = idle;
            mSent  = 1'b0;
        end
        cls     = classOf(op, funct3);
        expStb  = !cmdBusy && (mState == fetchAddr || (mState == fetchRead && !mSent));
        expWord = '0;
        if (expStb && mState == fetchAddr)
            expWord = {`CMD_SET_ADDR, 1'b0, 1'b0, pc[31:2]};   // Read, no increment
        else if (expStb)
            expWord = {`CMD_READ, 32'h0};
        if (expStb && !cmdStb)
        begin
            checks++;
            errors++;
            $display("Command strobe missing in %s with the bus idle at %0t ns",
                     mState.name(), $time);
        end
        else
            compareValue("cmdStb", 34'(expStb), 34'(cmdStb));
        compareValue("cmdWord", expWord, cmdWord);
        compareValue("ctrl", 34'(ctrlOf(mState, cls)), 34'(ctrl));
        compareValue("halted", 34'(mState == error), 34'(halted));
        if (!reset)
        begin
            case (mState)
                idle:      nState = fetchAddr;
                fetchAddr: nState = cmdBusy ? fetchAddr : pcIncr;
                pcIncr:    nState = fetchRead;
                fetchRead: nState = (mSent && rspStb) ? decode : fetchRead;
                decode:
                begin
                    case (cls)
                        clsLoad:   nState = memAddr;
                        clsStore:  nState = memAddr;
                        clsRType:  nState = executeR;
                        clsIType:  nState = executeI;
                        clsJal:    nState = jal;
                        clsBranch: nState = beq;
                        default:   nState = error;
                    endcase
                end
                memAddr:   nState = (cls == clsStore) ? memWrite : memRead;
                memRead:   nState = memWb;
                executeR:  nState = aluWb;
                executeI:  nState = aluWb;
                jal:       nState = aluWb;
                error:     nState = error;   // Held until reset
                default:   nState = fetchAddr;   // memWb, memWrite, beq, aluWb
            endcase
            mSent  = (mState == fetchRead) && (mSent || expStb);
            mState = nState;
        end
    end

endmodule

/* verif/tbTop.sv */
// Controller testbench top
// Seeded random instruction stream, bus responder and error recovery reset
// Batches focus on memory, ALU, jump/branch and a full mix with illegal codes
`timescale 1ns/1ns

`include "controller_defs.svh"

module tbTop;
    import ctrlPkg::*;

    localparam int NumInstr  = 400;
    localparam int MaxCycles = 40;    // Worst case per instruction
    localparam int BatchSize = 100;

    logic         clk;
    logic         porReset;
    logic         errReset;           // Pulse that clears the error state
    logic         reset;
    logic [6:0]   op;
    logic [2:0]   funct3;
    logic         funct7b5;
    logic         zero;
    logic [31:0]  pc;
    logic         cmdBusy;
    logic         rspStb;
    ctrlSignals_t ctrl;
    logic         cmdStb;
    busCmd_u      cmdWord;
    logic         halted;

    integer       seed = 20;
    logic [31:0]  rnd;                // Scratch draw, responder block only
    int           rspWait;            // Cycles left until the response
    int           haltCycles;
    int           instrCount;
    int           errResets;
    int           pool;               // 0 memory, 1 ALU, 2 jump/branch, 3 mixed

    assign reset = porReset | errReset;

    tbClock uClock (
        .clk   (clk),
        .reset (porReset)
    );

    multicycleController DUT (
        .clk      (clk),
        .reset    (reset),
        .op       (op),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .zero     (zero),
        .pc       (pc),
        .cmdBusy  (cmdBusy),
        .rspStb   (rspStb),
        .ctrl     (ctrl),
        .cmdStb   (cmdStb),
        .cmdWord  (cmdWord),
        .halted   (halted)
    );

    tbChecker uChecker (
        .clk      (clk),
        .reset    (reset),
        .op       (op),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .zero     (zero),
        .pc       (pc),
        .cmdBusy  (cmdBusy),
        .rspStb   (rspStb),
        .ctrl     (ctrl),
        .cmdStb   (cmdStb),
        .cmdWord  (cmdWord),
        .halted   (halted)
    );

    // Opcode drawn from the active batch's pool
    function automatic logic [6:0] pickOp(input int sel, input logic [31:0] r);
        int unsigned k;
        k = r % 100;
        case (sel)
            0:       return (k < 50) ? `OP_LOAD : `OP_STORE;
            1:       return (k < 50) ? `OP_RTYPE : `OP_ITYPE;
            2:       return (k < 50) ? `OP_JAL : `OP_BRANCH;
            default:
            begin
                if (k < 3)
                    return 7'b0110111;      // lui, not supported
                case (k % 6)
                    0:       return `OP_LOAD;
                    1:       return `OP_STORE;
                    2:       return `OP_RTYPE;
                    3:       return `OP_ITYPE;
                    4:       return `OP_JAL;
                    default: return `OP_BRANCH;
                endcase
            end
        endcase
    endfunction

    // Bus responder, instruction loader and error recovery
    always @(posedge clk)
    begin
        rnd = $random(seed);
        cmdBusy <= (rnd[1:0] == 2'b00);     // Busy about a quarter of cycles
        rspStb  <= 1'b0;
        if (cmdStb && cmdWord.dataForm.kind == `CMD_READ)
        begin
            rnd = $random(seed);
            rspWait = 1 + int'(rnd[1:0]);   // 1 to 4 cycles after the strobe
        end
        if (rspWait > 0)
        begin
            rspWait = rspWait - 1;
            if (rspWait == 0)
            begin
                rspStb <= 1'b1;
                rnd = $random(seed);
                op <= pickOp(pool, rnd);
                rnd = $random(seed);
                funct3   <= rnd[2:0];
                funct7b5 <= rnd[3];
                zero     <= rnd[4];
                pc       <= $random(seed);
                instrCount <= instrCount + 1;
            end
        end
        haltCycles <= halted ? haltCycles + 1 : 0;
        errReset   <= halted && haltCycles >= 3;   // Let halted hold a few cycles first
        if (halted && haltCycles == 3)
            errResets <= errResets + 1;
    end

    task automatic reportTest(input string name, input int errBase, input int chkBase);
        int newErrors;
        newErrors = uChecker.errors - errBase;
        $display("Test %-16s %7d checks  %0d errors  %s", name, uChecker.checks - chkBase,
                 newErrors, (newErrors == 0) ? "ok" : "FAILED");
    endtask

    task automatic runBatch(input string name, input int sel);
        int target;
        int errBase;
        int chkBase;
        @(negedge clk);
        pool    = sel;
        target  = instrCount + BatchSize;
        errBase = uChecker.errors;
        chkBase = uChecker.checks;
        while (instrCount < target)
            @(posedge clk);
        @(negedge clk);
        reportTest(name, errBase, chkBase);
    endtask

    initial
    begin
        cmdBusy    = 1'b0;
        rspStb     = 1'b0;
        op         = 7'd0;
        funct3     = 3'd0;
        funct7b5   = 1'b0;
        zero       = 1'b0;
        pc         = 32'd0;
        errReset   = 1'b0;
        rspWait    = 0;
        haltCycles = 0;
        instrCount = 0;
        errResets  = 0;
        pool       = 0;
        wait (porReset === 1'b0);
        repeat (2) @(negedge clk);    // Idle outputs, then the first fetchAddr
        reportTest("reset", 0, 0);
        runBatch("memory", 0);
        runBatch("alu", 1);
        runBatch("jump and branch", 2);
        runBatch("mixed", 3);
        $display("Tests 5, checks %0d, errors %0d, instructions %0d, error resets %0d",
                 uChecker.checks, uChecker.errors, instrCount, errResets);
        if (uChecker.errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(NumInstr * MaxCycles * 4 + 8 * 4);
        $display("Timeout, the run stalled after %0d instructions", instrCount);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* files.f */
+incdir+hdl
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/mainFsm.sv
hdl/fetchUnit.sv
hdl/ctrlEncoder.sv
hdl/multicycleController.sv
verif/tbClock.sv
verif/tbChecker.sv
verif/tbTop.sv

/* run.sh */
#!/bin/sh
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f files.f --top-module tbTop -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" sim.log; then
    exit 0
fi
exit 1
